// File: rtl/axi_bus_pkg.sv
/* Field widths of the AXI read channels (AR and R) only.
   Slave-side IDs are wider than master IDs and carry zero upper bits. */
`default_nettype none

package axi_bus_pkg;

  // ====================
  // AR channel
  // ====================
  localparam int ADDR_BITS  = 32;
  localparam int ID_BITS    = 4;
  localparam int IDS_BITS   = 8;
  localparam int LEN_BITS   = 4;
  localparam int SIZE_BITS  = 3;
  localparam int BURST_BITS = 2;

  // ====================
  // R channel
  // ====================
  localparam int DATA_BITS = 32;
  localparam int RESP_BITS = 2;

  // Normal access success
  localparam logic [RESP_BITS-1:0] RESP_OKAY = 2'b00;

endpackage

`default_nettype wire

// File: rtl/xbar_map_pkg.sv
/* Read address map: rom at 0x0000_0000 (8 KB), imem at 0x0001_0000 (64 KB),
   dram at 0x2000_0000 (2 MB). Other addresses are unmapped and must not be issued. */
`default_nettype none

package xbar_map_pkg;

  localparam int N_SLAVES = 3;

  typedef logic [1:0] slave_idx_t;

  localparam slave_idx_t SLV_ROM  = 2'd0;
  localparam slave_idx_t SLV_IMEM = 2'd1;
  localparam slave_idx_t SLV_DRAM = 2'd2;

  // ====================
  // Region tags
  // ====================
  localparam int ROM_TAG_BITS  = 19;
  localparam int IMEM_TAG_BITS = 16;
  localparam int DRAM_TAG_BITS = 11;

  localparam logic [ROM_TAG_BITS-1:0]  ROM_TAG  = 19'h0_0000;
  localparam logic [IMEM_TAG_BITS-1:0] IMEM_TAG = 16'h0001;
  localparam logic [DRAM_TAG_BITS-1:0] DRAM_TAG = 11'h100;

  // One address word, split per region
  typedef struct packed {
    logic [ROM_TAG_BITS-1:0]                        tag;
    logic [axi_bus_pkg::ADDR_BITS-ROM_TAG_BITS-1:0] offset;
  } rom_view_t;

  typedef struct packed {
    logic [IMEM_TAG_BITS-1:0]                        tag;
    logic [axi_bus_pkg::ADDR_BITS-IMEM_TAG_BITS-1:0] offset;
  } imem_view_t;

  typedef struct packed {
    logic [DRAM_TAG_BITS-1:0]                        tag;
    logic [axi_bus_pkg::ADDR_BITS-DRAM_TAG_BITS-1:0] offset;
  } dram_view_t;

  typedef union packed {
    logic [axi_bus_pkg::ADDR_BITS-1:0] word;
    rom_view_t                         rom;
    imem_view_t                        imem;
    dram_view_t                        dram;
  } map_addr_t;

  // Turn passes on after 2**TURN_CNT_BITS idle cycles
  localparam int TURN_CNT_BITS = 3;

  typedef enum logic [1:0] {
    GRANT_IDLE,
    GRANT_M0,
    GRANT_M1
  } grant_t;

endpackage

`default_nettype wire

// File: rtl/rd_arbiter.sv
/* Grants the read path to one master at a time, only to the turn holder.
   The target slave is decoded once at grant time from the request address. */
`timescale 1ns/1ps
`default_nettype none

module rd_arbiter (
  input  wire                                ACLK,
  input  wire                                ARESET,
  input  wire                                m0_ar_valid,
  input  wire                                m1_ar_valid,
  input  wire  [axi_bus_pkg::ADDR_BITS-1:0]  m0_ar_addr,
  input  wire  [axi_bus_pkg::ADDR_BITS-1:0]  m1_ar_addr,
  input  wire                                burst_done,
  output xbar_map_pkg::grant_t               grant,
  output xbar_map_pkg::slave_idx_t           target
);

  // 0 means m0 holds the turn
  logic                                   turn;
  logic [xbar_map_pkg::TURN_CNT_BITS-1:0] idle_cnt;
  logic                                   is_idle;
  logic                                   take_m0;
  logic                                   take_m1;
  xbar_map_pkg::map_addr_t                req_addr;
  xbar_map_pkg::slave_idx_t               req_slave;
  logic                                   req_hit;

  assign is_idle = (grant == xbar_map_pkg::GRANT_IDLE);
  assign take_m0 = is_idle && !turn && m0_ar_valid;
  assign take_m1 = is_idle && turn && m1_ar_valid;

  // ====================
  // Address decode
  // ====================
  always_comb begin
    req_addr.word = take_m1 ? m1_ar_addr : m0_ar_addr;
    req_hit       = 1'b1;
    if (req_addr.rom.tag == xbar_map_pkg::ROM_TAG) begin
      req_slave = xbar_map_pkg::SLV_ROM;
    end else if (req_addr.imem.tag == xbar_map_pkg::IMEM_TAG) begin
      req_slave = xbar_map_pkg::SLV_IMEM;
    end else if (req_addr.dram.tag == xbar_map_pkg::DRAM_TAG) begin
      req_slave = xbar_map_pkg::SLV_DRAM;
    end else begin
      req_slave = xbar_map_pkg::SLV_ROM;
      req_hit   = 1'b0;
    end
  end

  // ====================
  // Grant FSM
  // ====================
  always_ff @(posedge ACLK or posedge ARESET) begin
    if (ARESET) begin
      grant  <= xbar_map_pkg::GRANT_IDLE;
      target <= xbar_map_pkg::SLV_ROM;
    end else if (take_m0 || take_m1) begin
      grant  <= take_m0 ? xbar_map_pkg::GRANT_M0 : xbar_map_pkg::GRANT_M1;
      target <= req_slave;
    end else if (!is_idle && burst_done) begin
      grant <= xbar_map_pkg::GRANT_IDLE;
    end
  end

  // Turn and idle counter
  always_ff @(posedge ACLK or posedge ARESET) begin
    if (ARESET) begin
      turn     <= 1'b0;
      idle_cnt <= '0;
    end else if (!is_idle) begin
      idle_cnt <= '0;
      // Finished burst hands the turn to the other master
      if (burst_done) begin
        turn <= (grant == xbar_map_pkg::GRANT_M0);
      end
    end else begin
      idle_cnt <= idle_cnt + 1'b1;
      if (&idle_cnt && !take_m0 && !take_m1) begin
        turn <= !turn;
      end
    end
  end

  // Masters must only issue mapped addresses
  a_grant_mapped : assert property (@(posedge ACLK) disable iff (ARESET)
    (take_m0 || take_m1) |-> req_hit)
    else $error("rd_arbiter: granted address %h maps to no slave", req_addr.word);

  // Ownership always passes through idle
  a_grant_via_idle : assert property (@(posedge ACLK) disable iff (ARESET)
    !is_idle |=> (grant == $past(grant)) || (grant == xbar_map_pkg::GRANT_IDLE))
    else $error("rd_arbiter: grant moved between masters without idle");

endmodule

`default_nettype wire

// File: rtl/rd_router.sv
/* Combinational AR/R steering between the granted master and its target slave.
   Nothing is buffered; valid/ready pass straight through with no added cycles. */
`timescale 1ns/1ps
`default_nettype none

module rd_router (
  input  wire                                    ACLK,
  input  wire                                    ARESET,
  input  wire xbar_map_pkg::grant_t              grant,
  input  wire xbar_map_pkg::slave_idx_t          target,
  // Master 0
  input  wire  [axi_bus_pkg::ID_BITS-1:0]        m0_ar_id,
  input  wire  [axi_bus_pkg::ADDR_BITS-1:0]      m0_ar_addr,
  input  wire  [axi_bus_pkg::LEN_BITS-1:0]       m0_ar_len,
  input  wire  [axi_bus_pkg::SIZE_BITS-1:0]      m0_ar_size,
  input  wire  [axi_bus_pkg::BURST_BITS-1:0]     m0_ar_burst,
  input  wire                                    m0_ar_valid,
  input  wire                                    m0_r_ready,
  output logic                                   m0_ar_ready,
  output logic [axi_bus_pkg::ID_BITS-1:0]        m0_r_id,
  output logic [axi_bus_pkg::DATA_BITS-1:0]      m0_r_data,
  output logic [axi_bus_pkg::RESP_BITS-1:0]      m0_r_resp,
  output logic                                   m0_r_last,
  output logic                                   m0_r_valid,
  // Master 1
  input  wire  [axi_bus_pkg::ID_BITS-1:0]        m1_ar_id,
  input  wire  [axi_bus_pkg::ADDR_BITS-1:0]      m1_ar_addr,
  input  wire  [axi_bus_pkg::LEN_BITS-1:0]       m1_ar_len,
  input  wire  [axi_bus_pkg::SIZE_BITS-1:0]      m1_ar_size,
  input  wire  [axi_bus_pkg::BURST_BITS-1:0]     m1_ar_burst,
  input  wire                                    m1_ar_valid,
  input  wire                                    m1_r_ready,
  output logic                                   m1_ar_ready,
  output logic [axi_bus_pkg::ID_BITS-1:0]        m1_r_id,
  output logic [axi_bus_pkg::DATA_BITS-1:0]      m1_r_data,
  output logic [axi_bus_pkg::RESP_BITS-1:0]      m1_r_resp,
  output logic                                   m1_r_last,
  output logic                                   m1_r_valid,
  // Slaves, indexed by slave number
  output logic [xbar_map_pkg::N_SLAVES-1:0][axi_bus_pkg::IDS_BITS-1:0]   s_ar_id,
  output logic [xbar_map_pkg::N_SLAVES-1:0][axi_bus_pkg::ADDR_BITS-1:0]  s_ar_addr,
  output logic [xbar_map_pkg::N_SLAVES-1:0][axi_bus_pkg::LEN_BITS-1:0]   s_ar_len,
  output logic [xbar_map_pkg::N_SLAVES-1:0][axi_bus_pkg::SIZE_BITS-1:0]  s_ar_size,
  output logic [xbar_map_pkg::N_SLAVES-1:0][axi_bus_pkg::BURST_BITS-1:0] s_ar_burst,
  output logic [xbar_map_pkg::N_SLAVES-1:0]                              s_ar_valid,
  output logic [xbar_map_pkg::N_SLAVES-1:0]                              s_r_ready,
  input  wire  [xbar_map_pkg::N_SLAVES-1:0]                              s_ar_ready,
  input  wire  [xbar_map_pkg::N_SLAVES-1:0][axi_bus_pkg::IDS_BITS-1:0]   s_r_id,
  input  wire  [xbar_map_pkg::N_SLAVES-1:0][axi_bus_pkg::DATA_BITS-1:0]  s_r_data,
  input  wire  [xbar_map_pkg::N_SLAVES-1:0][axi_bus_pkg::RESP_BITS-1:0]  s_r_resp,
  input  wire  [xbar_map_pkg::N_SLAVES-1:0]                              s_r_last,
  input  wire  [xbar_map_pkg::N_SLAVES-1:0]                              s_r_valid,
  output logic                                   burst_done
);

  logic                                 sel_m0;
  logic                                 sel_m1;
  logic [axi_bus_pkg::ID_BITS-1:0]      sel_ar_id;
  logic [axi_bus_pkg::ADDR_BITS-1:0]    sel_ar_addr;
  logic [axi_bus_pkg::LEN_BITS-1:0]     sel_ar_len;
  logic [axi_bus_pkg::SIZE_BITS-1:0]    sel_ar_size;
  logic [axi_bus_pkg::BURST_BITS-1:0]   sel_ar_burst;
  logic                                 sel_ar_valid;
  logic                                 sel_r_ready;
  logic                                 tgt_ar_ready;
  logic [axi_bus_pkg::ID_BITS-1:0]      tgt_r_id;
  logic [axi_bus_pkg::DATA_BITS-1:0]    tgt_r_data;
  logic [axi_bus_pkg::RESP_BITS-1:0]    tgt_r_resp;
  logic                                 tgt_r_last;
  logic                                 tgt_r_valid;

  assign sel_m0 = (grant == xbar_map_pkg::GRANT_M0);
  assign sel_m1 = (grant == xbar_map_pkg::GRANT_M1);

  // Request side of the granted master
  assign sel_ar_id    = sel_m1 ? m1_ar_id    : m0_ar_id;
  assign sel_ar_addr  = sel_m1 ? m1_ar_addr  : m0_ar_addr;
  assign sel_ar_len   = sel_m1 ? m1_ar_len   : m0_ar_len;
  assign sel_ar_size  = sel_m1 ? m1_ar_size  : m0_ar_size;
  assign sel_ar_burst = sel_m1 ? m1_ar_burst : m0_ar_burst;
  assign sel_ar_valid = sel_m1 ? m1_ar_valid : (sel_m0 && m0_ar_valid);
  assign sel_r_ready  = sel_m1 ? m1_r_ready  : (sel_m0 && m0_r_ready);

  // ====================
  // Slave steering
  // ====================
  always_comb begin
    s_ar_id      = '0;
    s_ar_addr    = '0;
    s_ar_len     = '0;
    s_ar_size    = '0;
    s_ar_burst   = '0;
    s_ar_valid   = '0;
    s_r_ready    = '0;
    tgt_ar_ready = 1'b0;
    tgt_r_id     = '0;
    tgt_r_data   = '0;
    tgt_r_resp   = '0;
    tgt_r_last   = 1'b0;
    tgt_r_valid  = 1'b0;
    for (int i = 0; i < xbar_map_pkg::N_SLAVES; i++) begin
      if ((sel_m0 || sel_m1) && target == xbar_map_pkg::slave_idx_t'(i)) begin
        s_ar_id[i]    = {{(axi_bus_pkg::IDS_BITS-axi_bus_pkg::ID_BITS){1'b0}}, sel_ar_id};
        s_ar_addr[i]  = sel_ar_addr;
        s_ar_len[i]   = sel_ar_len;
        s_ar_size[i]  = sel_ar_size;
        s_ar_burst[i] = sel_ar_burst;
        s_ar_valid[i] = sel_ar_valid;
        s_r_ready[i]  = sel_r_ready;
        tgt_ar_ready  = s_ar_ready[i];
        tgt_r_id      = s_r_id[i][axi_bus_pkg::ID_BITS-1:0];
        tgt_r_data    = s_r_data[i];
        tgt_r_resp    = s_r_resp[i];
        tgt_r_last    = s_r_last[i];
        tgt_r_valid   = s_r_valid[i];
      end
    end
  end

  // Responses go back to the granted master only
  assign m0_ar_ready = sel_m0 && tgt_ar_ready;
  assign m0_r_id     = sel_m0 ? tgt_r_id   : '0;
  assign m0_r_data   = sel_m0 ? tgt_r_data : '0;
  assign m0_r_resp   = sel_m0 ? tgt_r_resp : '0;
  assign m0_r_last   = sel_m0 && tgt_r_last;
  assign m0_r_valid  = sel_m0 && tgt_r_valid;
  assign m1_ar_ready = sel_m1 && tgt_ar_ready;
  assign m1_r_id     = sel_m1 ? tgt_r_id   : '0;
  assign m1_r_data   = sel_m1 ? tgt_r_data : '0;
  assign m1_r_resp   = sel_m1 ? tgt_r_resp : '0;
  assign m1_r_last   = sel_m1 && tgt_r_last;
  assign m1_r_valid  = sel_m1 && tgt_r_valid;

  // Last beat accepted by the granted master
  assign burst_done = tgt_r_valid && tgt_r_last && sel_r_ready;

  a_one_slave_ar : assert property (@(posedge ACLK) disable iff (ARESET)
    $onehot0(s_ar_valid))
    else $error("rd_router: ar_valid raised toward more than one slave");

endmodule

`default_nettype wire

// File: rtl/axi_read_xbar.sv
/* Read-only crossbar, two masters to rom, imem and dram, one burst at a time.
   A master must not raise ar_valid for its next burst before the current one ends. */
`timescale 1ns/1ps
`default_nettype none

module axi_read_xbar (
  input  wire                                 ACLK,
  input  wire                                 ARESET,
  // ====================
  // Masters
  // ====================
  input  wire  [axi_bus_pkg::ID_BITS-1:0]     m0_ar_id, m1_ar_id,
  input  wire  [axi_bus_pkg::ADDR_BITS-1:0]   m0_ar_addr, m1_ar_addr,
  input  wire  [axi_bus_pkg::LEN_BITS-1:0]    m0_ar_len, m1_ar_len,
  input  wire  [axi_bus_pkg::SIZE_BITS-1:0]   m0_ar_size, m1_ar_size,
  input  wire  [axi_bus_pkg::BURST_BITS-1:0]  m0_ar_burst, m1_ar_burst,
  input  wire                                 m0_ar_valid, m1_ar_valid,
  input  wire                                 m0_r_ready, m1_r_ready,
  output logic                                m0_ar_ready, m1_ar_ready,
  output logic [axi_bus_pkg::ID_BITS-1:0]     m0_r_id, m1_r_id,
  output logic [axi_bus_pkg::DATA_BITS-1:0]   m0_r_data, m1_r_data,
  output logic [axi_bus_pkg::RESP_BITS-1:0]   m0_r_resp, m1_r_resp,
  output logic                                m0_r_last, m1_r_last,
  output logic                                m0_r_valid, m1_r_valid,
  // ====================
  // Slaves
  // ====================
  output logic [axi_bus_pkg::IDS_BITS-1:0]    s_rom_ar_id, s_imem_ar_id, s_dram_ar_id,
  output logic [axi_bus_pkg::ADDR_BITS-1:0]   s_rom_ar_addr, s_imem_ar_addr, s_dram_ar_addr,
  output logic [axi_bus_pkg::LEN_BITS-1:0]    s_rom_ar_len, s_imem_ar_len, s_dram_ar_len,
  output logic [axi_bus_pkg::SIZE_BITS-1:0]   s_rom_ar_size, s_imem_ar_size, s_dram_ar_size,
  output logic [axi_bus_pkg::BURST_BITS-1:0]  s_rom_ar_burst, s_imem_ar_burst,
                                              s_dram_ar_burst,
  output logic                                s_rom_ar_valid, s_imem_ar_valid,
                                              s_dram_ar_valid,
  output logic                                s_rom_r_ready, s_imem_r_ready, s_dram_r_ready,
  input  wire                                 s_rom_ar_ready, s_imem_ar_ready,
                                              s_dram_ar_ready,
  input  wire  [axi_bus_pkg::IDS_BITS-1:0]    s_rom_r_id, s_imem_r_id, s_dram_r_id,
  input  wire  [axi_bus_pkg::DATA_BITS-1:0]   s_rom_r_data, s_imem_r_data, s_dram_r_data,
  input  wire  [axi_bus_pkg::RESP_BITS-1:0]   s_rom_r_resp, s_imem_r_resp, s_dram_r_resp,
  input  wire                                 s_rom_r_last, s_imem_r_last, s_dram_r_last,
  input  wire                                 s_rom_r_valid, s_imem_r_valid, s_dram_r_valid
);

  xbar_map_pkg::grant_t     grant;
  xbar_map_pkg::slave_idx_t target;
  logic                     burst_done;

  logic [xbar_map_pkg::N_SLAVES-1:0][axi_bus_pkg::IDS_BITS-1:0]   s_ar_id;
  logic [xbar_map_pkg::N_SLAVES-1:0][axi_bus_pkg::ADDR_BITS-1:0]  s_ar_addr;
  logic [xbar_map_pkg::N_SLAVES-1:0][axi_bus_pkg::LEN_BITS-1:0]   s_ar_len;
  logic [xbar_map_pkg::N_SLAVES-1:0][axi_bus_pkg::SIZE_BITS-1:0]  s_ar_size;
  logic [xbar_map_pkg::N_SLAVES-1:0][axi_bus_pkg::BURST_BITS-1:0] s_ar_burst;
  logic [xbar_map_pkg::N_SLAVES-1:0]                              s_ar_valid;
  logic [xbar_map_pkg::N_SLAVES-1:0]                              s_r_ready;
  logic [xbar_map_pkg::N_SLAVES-1:0]                              s_ar_ready;
  logic [xbar_map_pkg::N_SLAVES-1:0][axi_bus_pkg::IDS_BITS-1:0]   s_r_id;
  logic [xbar_map_pkg::N_SLAVES-1:0][axi_bus_pkg::DATA_BITS-1:0]  s_r_data;
  logic [xbar_map_pkg::N_SLAVES-1:0][axi_bus_pkg::RESP_BITS-1:0]  s_r_resp;
  logic [xbar_map_pkg::N_SLAVES-1:0]                              s_r_last;
  logic [xbar_map_pkg::N_SLAVES-1:0]                              s_r_valid;

  // Concatenation order follows the slave indices: dram 2, imem 1, rom 0
  assign {s_dram_ar_id, s_imem_ar_id, s_rom_ar_id}          = s_ar_id;
  assign {s_dram_ar_addr, s_imem_ar_addr, s_rom_ar_addr}    = s_ar_addr;
  assign {s_dram_ar_len, s_imem_ar_len, s_rom_ar_len}       = s_ar_len;
  assign {s_dram_ar_size, s_imem_ar_size, s_rom_ar_size}    = s_ar_size;
  assign {s_dram_ar_burst, s_imem_ar_burst, s_rom_ar_burst} = s_ar_burst;
  assign {s_dram_ar_valid, s_imem_ar_valid, s_rom_ar_valid} = s_ar_valid;
  assign {s_dram_r_ready, s_imem_r_ready, s_rom_r_ready}    = s_r_ready;

  assign s_ar_ready = {s_dram_ar_ready, s_imem_ar_ready, s_rom_ar_ready};
  assign s_r_id     = {s_dram_r_id, s_imem_r_id, s_rom_r_id};
  assign s_r_data   = {s_dram_r_data, s_imem_r_data, s_rom_r_data};
  assign s_r_resp   = {s_dram_r_resp, s_imem_r_resp, s_rom_r_resp};
  assign s_r_last   = {s_dram_r_last, s_imem_r_last, s_rom_r_last};
  assign s_r_valid  = {s_dram_r_valid, s_imem_r_valid, s_rom_r_valid};

  rd_arbiter u_arbiter (
    .ACLK        (ACLK),
    .ARESET      (ARESET),
    .m0_ar_valid (m0_ar_valid),
    .m1_ar_valid (m1_ar_valid),
    .m0_ar_addr  (m0_ar_addr),
    .m1_ar_addr  (m1_ar_addr),
    .burst_done  (burst_done),
    .grant       (grant),
    .target      (target)
  );

  // Every router port has a same-named signal here
  rd_router u_router (.*);

endmodule

`default_nettype wire

// File: sim/tb_slave_model.sv
/* Behavioral AXI read slave. Accepts AR after 0 to 2 cycles and returns
   ar_len+1 beats of address plus 4 per beat, always OKAY. IDX names the slave only. */
`timescale 1ns/1ps
`default_nettype none

module tb_slave_model #(
  parameter int IDX = 0
) (
  input  wire                                ACLK,
  input  wire                                ARESET,
  input  wire  [axi_bus_pkg::IDS_BITS-1:0]   ar_id,
  input  wire  [axi_bus_pkg::ADDR_BITS-1:0]  ar_addr,
  input  wire  [axi_bus_pkg::LEN_BITS-1:0]   ar_len,
  input  wire                                ar_valid,
  input  wire                                r_ready,
  output logic                               ar_ready,
  output logic [axi_bus_pkg::IDS_BITS-1:0]   r_id,
  output logic [axi_bus_pkg::DATA_BITS-1:0]  r_data,
  output logic [axi_bus_pkg::RESP_BITS-1:0]  r_resp,
  output logic                               r_last,
  output logic                               r_valid
);

  logic                               busy;
  logic [1:0]                         wait_cnt;
  logic [axi_bus_pkg::ADDR_BITS-1:0]  base;
  logic [axi_bus_pkg::LEN_BITS-1:0]   len;
  logic [axi_bus_pkg::LEN_BITS-1:0]   beat;

  always @(posedge ACLK or posedge ARESET) begin
    if (ARESET) begin
      busy     <= 1'b0;
      wait_cnt <= 2'd0;
      base     <= '0;
      len      <= '0;
      beat     <= '0;
      ar_ready <= 1'b0;
      r_id     <= '0;
      r_data   <= '0;
      r_resp   <= '0;
      r_last   <= 1'b0;
      r_valid  <= 1'b0;
    end else if (!busy) begin
      if (ar_valid && ar_ready) begin
        ar_ready <= 1'b0;
        busy     <= 1'b1;
        base     <= ar_addr;
        len      <= ar_len;
        beat     <= '0;
        r_id     <= ar_id;
        wait_cnt <= 2'($urandom_range(2, 0));
      end else if (ar_valid) begin
        // Random AR acceptance delay
        if (wait_cnt == 2'd0) begin
          ar_ready <= 1'b1;
        end else begin
          wait_cnt <= wait_cnt - 2'd1;
        end
      end
    end else if (r_valid && r_ready) begin
      r_valid  <= 1'b0;
      r_last   <= 1'b0;
      wait_cnt <= 2'($urandom_range(2, 0));
      if (r_last) begin
        busy <= 1'b0;
      end else begin
        beat <= beat + 4'd1;
      end
    end else if (!r_valid) begin
      if (wait_cnt == 2'd0) begin
        r_valid <= 1'b1;
        r_data  <= base + {26'd0, beat, 2'b00};
        r_resp  <= axi_bus_pkg::RESP_OKAY;
        r_last  <= (beat == len);
      end else begin
        wait_cnt <= wait_cnt - 2'd1;
      end
    end
  end

endmodule

`default_nettype wire

// File: sim/tb_axi_read_xbar.sv
/* Two random masters, 150 bursts each, against three slave models.
   Checking is done by concurrent assertions; the run is capped at 12000 cycles. */
`timescale 1ns/1ps
`default_nettype none

module tb_axi_read_xbar;

  localparam int BURSTS     = 150;
  localparam int CYC_BURST  = 40;
  localparam int MAX_CYCLES = 2 * BURSTS * CYC_BURST;

  logic ACLK;
  logic ARESET;
  logic rst_d;
  int   errors;
  int   cycles;
  int   bursts_done;

  // Master side, index 0 is m0
  logic [1:0][3:0]  m_ar_id;
  logic [1:0][31:0] m_ar_addr;
  logic [1:0][3:0]  m_ar_len;
  logic [1:0][2:0]  m_ar_size;
  logic [1:0][1:0]  m_ar_burst;
  logic [1:0]       m_ar_valid;
  logic [1:0]       m_r_ready;
  logic [1:0]       m_ar_ready;
  logic [1:0][3:0]  m_r_id;
  logic [1:0][31:0] m_r_data;
  logic [1:0][1:0]  m_r_resp;
  logic [1:0]       m_r_last;
  logic [1:0]       m_r_valid;

  // Slave side, index 0 rom, 1 imem, 2 dram
  logic [2:0][7:0]  s_ar_id;
  logic [2:0][31:0] s_ar_addr;
  logic [2:0][3:0]  s_ar_len;
  logic [2:0][2:0]  s_ar_size;
  logic [2:0][1:0]  s_ar_burst;
  logic [2:0]       s_ar_valid;
  logic [2:0]       s_r_ready;
  logic [2:0]       s_ar_ready;
  logic [2:0][7:0]  s_r_id;
  logic [2:0][31:0] s_r_data;
  logic [2:0][1:0]  s_r_resp;
  logic [2:0]       s_r_last;
  logic [2:0]       s_r_valid;

  // Reference state per master
  logic [1:0][31:0] exp_addr;
  logic [1:0][3:0]  exp_id;
  logic [1:0][3:0]  exp_len;
  logic [1:0][3:0]  beat;
  logic [1:0]       in_burst;
  logic [1:0][4:0]  req_wait;
  logic             pend;
  logic             pend_owner;
  logic [1:0]       accept;
  logic [1:0]       burst_end;

  assign accept    = m_ar_valid & m_ar_ready;
  assign burst_end = m_r_valid & m_r_ready & m_r_last;

  axi_read_xbar dut (
    .ACLK (ACLK), .ARESET (ARESET),
    .m0_ar_id (m_ar_id[0]), .m1_ar_id (m_ar_id[1]),
    .m0_ar_addr (m_ar_addr[0]), .m1_ar_addr (m_ar_addr[1]),
    .m0_ar_len (m_ar_len[0]), .m1_ar_len (m_ar_len[1]),
    .m0_ar_size (m_ar_size[0]), .m1_ar_size (m_ar_size[1]),
    .m0_ar_burst (m_ar_burst[0]), .m1_ar_burst (m_ar_burst[1]),
    .m0_ar_valid (m_ar_valid[0]), .m1_ar_valid (m_ar_valid[1]),
    .m0_r_ready (m_r_ready[0]), .m1_r_ready (m_r_ready[1]),
    .m0_ar_ready (m_ar_ready[0]), .m1_ar_ready (m_ar_ready[1]),
    .m0_r_id (m_r_id[0]), .m1_r_id (m_r_id[1]),
    .m0_r_data (m_r_data[0]), .m1_r_data (m_r_data[1]),
    .m0_r_resp (m_r_resp[0]), .m1_r_resp (m_r_resp[1]),
    .m0_r_last (m_r_last[0]), .m1_r_last (m_r_last[1]),
    .m0_r_valid (m_r_valid[0]), .m1_r_valid (m_r_valid[1]),
    .s_rom_ar_id (s_ar_id[0]), .s_imem_ar_id (s_ar_id[1]), .s_dram_ar_id (s_ar_id[2]),
    .s_rom_ar_addr (s_ar_addr[0]), .s_imem_ar_addr (s_ar_addr[1]),
    .s_dram_ar_addr (s_ar_addr[2]),
    .s_rom_ar_len (s_ar_len[0]), .s_imem_ar_len (s_ar_len[1]), .s_dram_ar_len (s_ar_len[2]),
    .s_rom_ar_size (s_ar_size[0]), .s_imem_ar_size (s_ar_size[1]),
    .s_dram_ar_size (s_ar_size[2]),
    .s_rom_ar_burst (s_ar_burst[0]), .s_imem_ar_burst (s_ar_burst[1]),
    .s_dram_ar_burst (s_ar_burst[2]),
    .s_rom_ar_valid (s_ar_valid[0]), .s_imem_ar_valid (s_ar_valid[1]),
    .s_dram_ar_valid (s_ar_valid[2]),
    .s_rom_r_ready (s_r_ready[0]), .s_imem_r_ready (s_r_ready[1]),
    .s_dram_r_ready (s_r_ready[2]),
    .s_rom_ar_ready (s_ar_ready[0]), .s_imem_ar_ready (s_ar_ready[1]),
    .s_dram_ar_ready (s_ar_ready[2]),
    .s_rom_r_id (s_r_id[0]), .s_imem_r_id (s_r_id[1]), .s_dram_r_id (s_r_id[2]),
    .s_rom_r_data (s_r_data[0]), .s_imem_r_data (s_r_data[1]), .s_dram_r_data (s_r_data[2]),
    .s_rom_r_resp (s_r_resp[0]), .s_imem_r_resp (s_r_resp[1]), .s_dram_r_resp (s_r_resp[2]),
    .s_rom_r_last (s_r_last[0]), .s_imem_r_last (s_r_last[1]), .s_dram_r_last (s_r_last[2]),
    .s_rom_r_valid (s_r_valid[0]), .s_imem_r_valid (s_r_valid[1]),
    .s_dram_r_valid (s_r_valid[2])
  );

  task automatic note_failure(input string msg);
    errors++;
    $display("FAILED at %0t: %s", $time, msg);
  endtask

  function automatic logic in_region(input int s, input logic [31:0] a);
    case (s)
      0:       return a[31:13] == 19'h0;
      1:       return a[31:16] == 16'h0001;
      default: return a[31:21] == 11'h100;
    endcase
  endfunction

  // Random 16-byte aligned address, so a 4-beat burst stays in its region
  function automatic logic [31:0] pick_address(input int region);
    case (region)
      0:       return {19'h0, 13'($urandom) & 13'h1FF0};
      1:       return {16'h0001, 16'($urandom) & 16'hFFF0};
      default: return {11'h100, 21'($urandom) & 21'h1F_FFF0};
    endcase
  endfunction

  // ====================
  // Clock and bookkeeping
  // ====================
  always #5 ACLK = ~ACLK;

  always @(posedge ACLK) begin
    rst_d  <= ARESET;
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES) begin
      $display("Timeout: %0d of %0d bursts completed in %0d cycles, %0d errors",
               bursts_done, 2 * BURSTS, MAX_CYCLES, errors);
      $display("Test failed");
      $finish;
    end
  end

  always @(posedge ACLK or posedge ARESET) begin
    if (ARESET) begin
      beat       <= '0;
      in_burst   <= '0;
      req_wait   <= '0;
      pend       <= 1'b0;
      pend_owner <= 1'b0;
    end else begin
      for (int m = 0; m < 2; m++) begin
        if (m_r_valid[m] && m_r_ready[m]) begin
          beat[m] <= m_r_last[m] ? 4'd0 : beat[m] + 4'd1;
        end
        if (accept[m]) begin
          in_burst[m] <= 1'b1;
        end else if (burst_end[m]) begin
          in_burst[m] <= 1'b0;
        end
        // Lone request on an idle path, not yet routed to a slave
        if (m_ar_valid[m] && !m_ar_valid[1-m] && in_burst == 2'b00 && s_ar_valid == 3'b000) begin
          req_wait[m] <= req_wait[m] + 5'd1;
        end else begin
          req_wait[m] <= 5'd0;
        end
      end
      if (burst_end[0] && m_ar_valid[1]) begin
        pend       <= 1'b1;
        pend_owner <= 1'b1;
      end else if (burst_end[1] && m_ar_valid[0]) begin
        pend       <= 1'b1;
        pend_owner <= 1'b0;
      end else if (accept != 2'b00) begin
        pend <= 1'b0;
      end
    end
  end

  // ====================
  // Checks
  // ====================
  a_reset_quiet : assert property (@(posedge ACLK)
    (ARESET || rst_d) |-> (m_ar_ready == 2'b00 && m_r_valid == 2'b00 &&
                           s_ar_valid == 3'b000 && s_r_ready == 3'b000))
    else note_failure("handshake signals active during or right after reset");

  for (genvar s = 0; s < 3; s++) begin : g_slave
    tb_slave_model #(.IDX(s)) u_slave (
      .ACLK (ACLK), .ARESET (ARESET),
      .ar_id (s_ar_id[s]), .ar_addr (s_ar_addr[s]), .ar_len (s_ar_len[s]),
      .ar_valid (s_ar_valid[s]), .r_ready (s_r_ready[s]), .ar_ready (s_ar_ready[s]),
      .r_id (s_r_id[s]), .r_data (s_r_data[s]), .r_resp (s_r_resp[s]),
      .r_last (s_r_last[s]), .r_valid (s_r_valid[s])
    );

    a_ar_region : assert property (@(posedge ACLK) disable iff (ARESET)
      s_ar_valid[s] |-> (in_region(s, s_ar_addr[s]) &&
                         (s_ar_valid & ~(3'b001 << s)) == 3'b000 &&
                         (s_r_ready & ~(3'b001 << s)) == 3'b000))
      else note_failure($sformatf("slave %0d got AR %h outside its region or not alone",
                                  s, s_ar_addr[s]));

    a_ar_source : assert property (@(posedge ACLK) disable iff (ARESET)
      (s_ar_valid[s] && s_ar_ready[s]) |->
        ((m_ar_ready == 2'b01 && s_ar_addr[s] == m_ar_addr[0] &&
          s_ar_id[s] == {4'h0, m_ar_id[0]} && s_ar_len[s] == m_ar_len[0] &&
          s_ar_size[s] == m_ar_size[0] && s_ar_burst[s] == m_ar_burst[0]) ||
         (m_ar_ready == 2'b10 && s_ar_addr[s] == m_ar_addr[1] &&
          s_ar_id[s] == {4'h0, m_ar_id[1]} && s_ar_len[s] == m_ar_len[1] &&
          s_ar_size[s] == m_ar_size[1] && s_ar_burst[s] == m_ar_burst[1])))
      else note_failure($sformatf("slave %0d AR does not match the ready master", s));
  end

  for (genvar m = 0; m < 2; m++) begin : g_master
    a_beat_data : assert property (@(posedge ACLK) disable iff (ARESET)
      (m_r_valid[m] && m_r_ready[m]) |->
        (m_r_data[m] == exp_addr[m] + {26'd0, beat[m], 2'b00} && m_r_id[m] == exp_id[m] &&
         m_r_resp[m] == 2'b00 && m_r_last[m] == (beat[m] == exp_len[m]) && !m_r_valid[1-m]))
      else note_failure($sformatf("m%0d beat %0d data %h id %h last %b", m, beat[m],
                                  m_r_data[m], m_r_id[m], m_r_last[m]));

    a_turn_passes : assert property (@(posedge ACLK) disable iff (ARESET)
      accept[m] |-> !(pend && pend_owner != m))
      else note_failure($sformatf("m%0d accepted although the turn had passed on", m));

    a_lone_request : assert property (@(posedge ACLK) disable iff (ARESET)
      req_wait[m] <= 5'd10)
      else note_failure($sformatf("m%0d request waited more than 10 idle cycles", m));

    a_ready_low : assert property (@(posedge ACLK) disable iff (ARESET)
      (m_r_valid[m] && !m_r_ready[m]) |-> (s_r_ready == 3'b000))
      else note_failure($sformatf("slave saw r_ready while m%0d held it low", m));

    a_beat_holds : assert property (@(posedge ACLK) disable iff (ARESET)
      (m_r_valid[m] && !m_r_ready[m]) |=> (m_r_valid[m] && $stable(m_r_data[m])))
      else note_failure($sformatf("m%0d beat changed before it was accepted", m));
  end

  // ====================
  // Stimulus
  // ====================
  always @(posedge ACLK) begin
    m_r_ready[0] <= ($urandom_range(3, 0) != 0);
    m_r_ready[1] <= ($urandom_range(3, 0) != 0);
  end

  task automatic run_master(input int m);
    logic [31:0] addr;
    for (int n = 0; n < BURSTS; n++) begin
      addr = pick_address($urandom_range(2, 0));
      @(posedge ACLK);
      m_ar_addr[m]  <= addr;
      m_ar_id[m]    <= 4'($urandom);
      m_ar_len[m]   <= 4'($urandom_range(3, 0));
      m_ar_size[m]  <= 3'($urandom_range(2, 0));
      m_ar_burst[m] <= 2'($urandom_range(1, 0));
      m_ar_valid[m] <= 1'b1;
      do @(negedge ACLK); while (!m_ar_ready[m]);
      exp_addr[m] = m_ar_addr[m];
      exp_id[m]   = m_ar_id[m];
      exp_len[m]  = m_ar_len[m];
      @(posedge ACLK);
      m_ar_valid[m] <= 1'b0;
      do @(negedge ACLK); while (!burst_end[m]);
      bursts_done++;
      // Gaps longer than a burst leave the turn holder silent
      repeat ($urandom_range(24, 0)) @(posedge ACLK);
    end
  endtask

  initial begin
    ACLK        = 1'b0;
    ARESET      = 1'b1;
    rst_d       = 1'b1;
    errors      = 0;
    cycles      = 0;
    bursts_done = 0;
    m_ar_id     = '0;
    m_ar_addr   = '0;
    m_ar_len    = '0;
    m_ar_size   = {3'd2, 3'd2};
    m_ar_burst  = {2'b01, 2'b01};
    m_ar_valid  = '0;
    m_r_ready   = '0;
    exp_addr    = '0;
    exp_id      = '0;
    exp_len     = '0;
    void'($urandom(32'hdd30_d687));
    repeat (16) @(posedge ACLK);
    ARESET <= 1'b0;
    fork
      run_master(0);
      run_master(1);
    join
    repeat (4) @(posedge ACLK);
    $display("Bursts completed: %0d, errors: %0d", bursts_done, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: axi_read_xbar.f
rtl/axi_bus_pkg.sv
rtl/xbar_map_pkg.sv
rtl/rd_arbiter.sv
rtl/rd_router.sv
rtl/axi_read_xbar.sv
sim/tb_slave_model.sv
sim/tb_axi_read_xbar.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_axi_read_xbar -f axi_read_xbar.f -o sim_axi_read_xbar
./obj_dir/sim_axi_read_xbar > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log || ! grep -q "Test completed successfully" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi
echo "Simulation passed"
